// ==== dcache_pkg.sv ====
package dcache_pkg;

    //////////////////////////////
    // widths and geometry
    //////////////////////////////

    localparam int ADDR_WIDTH   = 32;
    localparam int DATA_WIDTH   = 32;
    localparam int OFFSET_WIDTH = 2;
    localparam int BYTE_COUNT   = DATA_WIDTH / 8;

    localparam int WAY_COUNT = 4;
    localparam int WAY_WIDTH = 2;

    // ages saturate instead of wrapping
    localparam int                   AGE_WIDTH = 4;
    localparam logic [AGE_WIDTH-1:0] AGE_MAX   = 4'd15;

    // processor access size encoding
    localparam logic [1:0] SIZE_BYTE = 2'b00;
    localparam logic [1:0] SIZE_HALF = 2'b01;
    localparam logic [1:0] SIZE_WORD = 2'b10;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITEBACK,
        ST_REFILL
    } mem_state_t;

    // one data word, seen whole or byte by byte
    typedef union packed {
        logic [DATA_WIDTH-1:0]           word;
        logic [BYTE_COUNT-1:0][7:0]      bytes;
    } data_word_u;

endpackage

// ==== dcache_miss_if.sv ====
`timescale 1ns/1ns

interface dcache_miss_if #(
    parameter int INDEX_WIDTH = 4
);
    import dcache_pkg::*;

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    // lookup results from the store
    logic                  hit;
    logic                  victim_dirty;
    logic [TAG_WIDTH-1:0]  victim_tag;
    logic [DATA_WIDTH-1:0] victim_data;

    // refill write, single cycle pulse
    logic                   refill_valid;
    logic [INDEX_WIDTH-1:0] refill_index;
    logic [TAG_WIDTH-1:0]   refill_tag;
    logic [DATA_WIDTH-1:0]  refill_data;

    // way to evict in the current set
    logic [WAY_WIDTH-1:0] victim_way;

    modport store (
        output hit, victim_dirty, victim_tag, victim_data,
        input  refill_valid, refill_index, refill_tag, refill_data, victim_way
    );

    modport ctrl (
        input  hit, victim_dirty, victim_tag, victim_data,
        output refill_valid, refill_index, refill_tag, refill_data
    );

    modport repl (
        input  hit, refill_valid, refill_index,
        output victim_way
    );

endinterface

// ==== dcache_store.sv ====
`timescale 1ns/1ns

module dcache_store #(
    parameter int INDEX_WIDTH = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cpu_req,
    input  logic                              cpu_wr,
    input  logic [1:0]                        cpu_size,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] cpu_addr,
    input  dcache_pkg::data_word_u            cpu_wdata,
    output dcache_pkg::data_word_u            cpu_rdata,
    output logic                              cpu_addr_ok,
    output logic                              cpu_data_ok,
    output logic [dcache_pkg::WAY_WIDTH-1:0]  hit_way,
    dcache_miss_if.store                      miss
);
    import dcache_pkg::*;

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int SET_COUNT = 1 << INDEX_WIDTH;

    //////////////////////////////
    // arrays
    //////////////////////////////

    logic [WAY_COUNT-1:0] valid_q [SET_COUNT];
    logic [WAY_COUNT-1:0] dirty_q [SET_COUNT];
    logic [TAG_WIDTH-1:0] tag_q   [SET_COUNT][WAY_COUNT];
    data_word_u           data_q  [SET_COUNT][WAY_COUNT];

    logic [OFFSET_WIDTH-1:0] offset;
    logic [INDEX_WIDTH-1:0]  index;
    logic [TAG_WIDTH-1:0]    tag;

    logic [WAY_COUNT-1:0]  way_match;
    logic [BYTE_COUNT-1:0] byte_mask;
    data_word_u            hit_word;
    data_word_u            merged;
    logic                  wr_hit;

    assign offset = cpu_addr[OFFSET_WIDTH-1:0];
    assign index  = cpu_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign tag    = cpu_addr[ADDR_WIDTH-1 -: TAG_WIDTH];

    //////////////////////////////
    // lookup
    //////////////////////////////

    always_comb begin
        for (int w = 0; w < WAY_COUNT; w++) begin
            way_match[w] = valid_q[index][w] && (tag_q[index][w] == tag);
        end
    end

    // lowest matching way wins, though only one should ever match
    always_comb begin
        hit_way = '0;
        for (int w = WAY_COUNT - 1; w >= 0; w--) begin
            if (way_match[w]) begin
                hit_way = WAY_WIDTH'(w);
            end
        end
    end

    assign miss.hit  = |way_match;
    assign hit_word  = data_q[index][hit_way];
    assign cpu_rdata = hit_word;

    assign cpu_addr_ok = cpu_req & miss.hit;
    assign cpu_data_ok = cpu_req & miss.hit;

    // victim line for the miss controller
    assign miss.victim_dirty = valid_q[index][miss.victim_way] & dirty_q[index][miss.victim_way];
    assign miss.victim_tag   = tag_q[index][miss.victim_way];
    assign miss.victim_data  = data_q[index][miss.victim_way].word;

    //////////////////////////////
    // store merge
    //////////////////////////////

    always_comb begin
        case (cpu_size)
            SIZE_BYTE: byte_mask = 4'b0001 << offset;
            SIZE_HALF: byte_mask = offset[1] ? 4'b1100 : 4'b0011;
            default:   byte_mask = 4'b1111;
        endcase
    end

    always_comb begin
        merged = hit_word;
        for (int b = 0; b < BYTE_COUNT; b++) begin
            if (byte_mask[b]) begin
                merged.bytes[b] = cpu_wdata.bytes[b];
            end
        end
    end

    assign wr_hit = cpu_req & cpu_wr & miss.hit;

    // valid and dirty bits
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SET_COUNT; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (miss.refill_valid) begin
            valid_q[miss.refill_index][miss.victim_way] <= 1'b1;
            dirty_q[miss.refill_index][miss.victim_way] <= 1'b0;
        end else if (wr_hit) begin
            dirty_q[index][hit_way] <= 1'b1;
        end
    end

    // tags and data
    always_ff @(posedge clk) begin
        if (miss.refill_valid) begin
            tag_q[miss.refill_index][miss.victim_way]       <= miss.refill_tag;
            data_q[miss.refill_index][miss.victim_way].word <= miss.refill_data;
        end else if (wr_hit) begin
            data_q[index][hit_way] <= merged;
        end
    end

endmodule

// ==== dcache_replace.sv ====
`timescale 1ns/1ns

module dcache_replace #(
    parameter int INDEX_WIDTH = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cpu_req,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] cpu_addr,
    input  logic [dcache_pkg::WAY_WIDTH-1:0]  hit_way,
    dcache_miss_if.repl                       miss
);
    import dcache_pkg::*;

    localparam int SET_COUNT = 1 << INDEX_WIDTH;

    logic [AGE_WIDTH-1:0] age_q    [SET_COUNT][WAY_COUNT];
    logic [WAY_WIDTH-1:0] victim_q [SET_COUNT];

    logic [INDEX_WIDTH-1:0] cpu_index;
    logic                   upd_valid;
    logic [INDEX_WIDTH-1:0] upd_index;
    logic [WAY_WIDTH-1:0]   upd_way;
    logic [AGE_WIDTH-1:0]   new_age [WAY_COUNT];
    logic [AGE_WIDTH-1:0]   oldest_age;
    logic [WAY_WIDTH-1:0]   new_victim;

    assign cpu_index = cpu_addr[OFFSET_WIDTH +: INDEX_WIDTH];

    // refill takes the slot, a hit cannot happen while a refill lands
    assign upd_valid = (cpu_req & miss.hit) | miss.refill_valid;
    assign upd_index = miss.refill_valid ? miss.refill_index : cpu_index;
    assign upd_way   = miss.refill_valid ? miss.victim_way : hit_way;

    //////////////////////////////
    // age update
    //////////////////////////////

    always_comb begin
        for (int w = 0; w < WAY_COUNT; w++) begin
            if (WAY_WIDTH'(w) == upd_way) begin
                new_age[w] = '0;
            end else if (age_q[upd_index][w] == AGE_MAX) begin
                new_age[w] = AGE_MAX;
            end else begin
                new_age[w] = age_q[upd_index][w] + AGE_WIDTH'(1);
            end
        end
    end

    // oldest way, strict compare keeps the lowest way on ties
    always_comb begin
        oldest_age = new_age[0];
        new_victim = '0;
        for (int w = 1; w < WAY_COUNT; w++) begin
            if (new_age[w] > oldest_age) begin
                oldest_age = new_age[w];
                new_victim = WAY_WIDTH'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SET_COUNT; s++) begin
                victim_q[s] <= '0;
                for (int w = 0; w < WAY_COUNT; w++) begin
                    age_q[s][w] <= AGE_WIDTH'(1);
                end
            end
        end else if (upd_valid) begin
            for (int w = 0; w < WAY_COUNT; w++) begin
                age_q[upd_index][w] <= new_age[w];
            end
            victim_q[upd_index] <= new_victim;
        end
    end

    assign miss.victim_way = victim_q[cpu_index];

endmodule

// ==== dcache_miss_ctrl.sv ====
`timescale 1ns/1ns

module dcache_miss_ctrl #(
    parameter int INDEX_WIDTH = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cpu_req,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] cpu_addr,
    output logic                              mem_req,
    output logic                              mem_wr,
    output logic [dcache_pkg::ADDR_WIDTH-1:0] mem_addr,
    output logic [dcache_pkg::DATA_WIDTH-1:0] mem_wdata,
    input  logic [dcache_pkg::DATA_WIDTH-1:0] mem_rdata,
    input  logic                              mem_addr_ok,
    input  logic                              mem_data_ok,
    dcache_miss_if.ctrl                       miss
);
    import dcache_pkg::*;

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    mem_state_t state_q;
    mem_state_t state_d;
    logic       addr_acc_q;

    logic [TAG_WIDTH-1:0]   req_tag_q;
    logic [INDEX_WIDTH-1:0] req_index_q;
    logic [TAG_WIDTH-1:0]   victim_tag_q;
    logic [DATA_WIDTH-1:0]  victim_data_q;

    logic start;
    logic accepted;
    logic data_done;

    assign start = (state_q == ST_IDLE) & cpu_req & ~miss.hit;

    // address taken now or earlier, data_ok may follow in the same cycle
    assign accepted  = addr_acc_q | (mem_req & mem_addr_ok);
    assign data_done = accepted & mem_data_ok;

    //////////////////////////////
    // state machine
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (start) begin
                    state_d = miss.victim_dirty ? ST_WRITEBACK : ST_REFILL;
                end
            end
            ST_WRITEBACK: begin
                if (data_done) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (data_done) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ST_IDLE;
            addr_acc_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (data_done) begin
                addr_acc_q <= 1'b0;
            end else if (mem_req & mem_addr_ok) begin
                addr_acc_q <= 1'b1;
            end
        end
    end

    // request and victim snapshot on leaving idle
    always_ff @(posedge clk) begin
        if (start) begin
            req_tag_q     <= cpu_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
            req_index_q   <= cpu_addr[OFFSET_WIDTH +: INDEX_WIDTH];
            victim_tag_q  <= miss.victim_tag;
            victim_data_q <= miss.victim_data;
        end
    end

    //////////////////////////////
    // memory port
    //////////////////////////////

    assign mem_req   = (state_q != ST_IDLE) & ~addr_acc_q;
    assign mem_wr    = (state_q == ST_WRITEBACK);
    assign mem_wdata = victim_data_q;
    assign mem_addr  = (state_q == ST_WRITEBACK) ?
                       {victim_tag_q, req_index_q, {OFFSET_WIDTH{1'b0}}} :
                       {req_tag_q, req_index_q, {OFFSET_WIDTH{1'b0}}};

    assign miss.refill_valid = (state_q == ST_REFILL) & data_done;
    assign miss.refill_index = req_index_q;
    assign miss.refill_tag   = req_tag_q;
    assign miss.refill_data  = mem_rdata;

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/1ns

module dcache_top #(
    parameter int INDEX_WIDTH = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    // processor side
    input  logic                              cpu_req,
    input  logic                              cpu_wr,
    input  logic [1:0]                        cpu_size,
    input  logic [dcache_pkg::ADDR_WIDTH-1:0] cpu_addr,
    input  logic [dcache_pkg::DATA_WIDTH-1:0] cpu_wdata,
    output logic [dcache_pkg::DATA_WIDTH-1:0] cpu_rdata,
    output logic                              cpu_addr_ok,
    output logic                              cpu_data_ok,
    // memory side
    output logic                              mem_req,
    output logic                              mem_wr,
    output logic [dcache_pkg::ADDR_WIDTH-1:0] mem_addr,
    output logic [dcache_pkg::DATA_WIDTH-1:0] mem_wdata,
    input  logic [dcache_pkg::DATA_WIDTH-1:0] mem_rdata,
    input  logic                              mem_addr_ok,
    input  logic                              mem_data_ok
);
    import dcache_pkg::*;

    data_word_u           wdata_word;
    data_word_u           rdata_word;
    logic [WAY_WIDTH-1:0] hit_way;

    assign wdata_word.word = cpu_wdata;
    assign cpu_rdata       = rdata_word.word;

    dcache_miss_if #(.INDEX_WIDTH(INDEX_WIDTH)) miss_bus ();

    dcache_store #(.INDEX_WIDTH(INDEX_WIDTH)) i_store (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_wr     (cpu_wr),
        .cpu_size   (cpu_size),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (wdata_word),
        .cpu_rdata  (rdata_word),
        .cpu_addr_ok(cpu_addr_ok),
        .cpu_data_ok(cpu_data_ok),
        .hit_way    (hit_way),
        .miss       (miss_bus.store)
    );

    dcache_replace #(.INDEX_WIDTH(INDEX_WIDTH)) i_replace (
        .clk     (clk),
        .rst     (rst),
        .cpu_req (cpu_req),
        .cpu_addr(cpu_addr),
        .hit_way (hit_way),
        .miss    (miss_bus.repl)
    );

    dcache_miss_ctrl #(.INDEX_WIDTH(INDEX_WIDTH)) i_miss_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_addr   (cpu_addr),
        .mem_req    (mem_req),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok),
        .miss       (miss_bus.ctrl)
    );

endmodule

// ==== tb_mem.sv ====
`timescale 1ns/1ns

module tb_mem (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_req,
    input  logic        mem_wr,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    output logic [31:0] mem_rdata,
    output logic        mem_addr_ok,
    output logic        mem_data_ok
);
    // backing store, word addressed
    logic [31:0] store [logic [31:0]];

    function automatic logic [31:0] initial_word(input logic [31:0] key);
        return (key * 32'h9e37_79b1) ^ 32'h3c6e_f372;
    endfunction

    initial begin
        logic [31:0] key;
        logic [31:0] wdata;
        logic        wr;
        int          delay;
        mem_rdata   = 32'd0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && mem_req) begin
                // address phase
                delay = int'($urandom_range(5, 0));
                repeat (delay) @(negedge clk);
                @(posedge clk);
                #1;
                mem_addr_ok = 1'b1;
                key         = {mem_addr[31:2], 2'b00};
                wr          = mem_wr;
                wdata       = mem_wdata;
                @(posedge clk);
                #1;
                mem_addr_ok = 1'b0;
                if (wr) begin
                    store[key] = wdata;
                end
                // data phase
                delay = int'($urandom_range(5, 0));
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                mem_data_ok = 1'b1;
                mem_rdata   = store.exists(key) ? store[key] : initial_word(key);
                @(posedge clk);
                #1;
                mem_data_ok = 1'b0;
            end
        end
    end

endmodule

// ==== tb_dcache_assertions.sv ====
`timescale 1ns/1ns

module tb_dcache_assertions (
    input logic        clk,
    input logic        rst,
    input logic        cpu_req,
    input logic        cpu_data_ok,
    input logic        mem_req,
    input logic        mem_wr,
    input logic [31:0] mem_addr,
    input logic [31:0] mem_wdata,
    input logic        mem_addr_ok,
    input logic        mem_data_ok
);
    // accepted access still waiting for its mem_data_ok
    logic data_owed;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_owed <= 1'b0;
        end else if (mem_data_ok) begin
            data_owed <= 1'b0;
        end else if (mem_req && mem_addr_ok) begin
            data_owed <= 1'b1;
        end
    end

    hold_until_accept: assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_addr_ok |=>
            mem_req && $stable(mem_wr) && $stable(mem_addr) && $stable(mem_wdata))
        else $error("memory request changed before mem_addr_ok");

    no_req_while_owed: assert property (@(posedge clk) disable iff (rst)
        data_owed |-> !mem_req)
        else $error("mem_req raised while a mem_data_ok is still owed");

    // memory traffic only serves a processor request that is still missing
    miss_only_traffic: assert property (@(posedge clk) disable iff (rst)
        mem_req |-> cpu_req && !cpu_data_ok)
        else $error("memory request without a pending processor miss");

endmodule

bind dcache_top tb_dcache_assertions i_assertions (
    .clk        (clk),
    .rst        (rst),
    .cpu_req    (cpu_req),
    .cpu_data_ok(cpu_data_ok),
    .mem_req    (mem_req),
    .mem_wr     (mem_wr),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_addr_ok(mem_addr_ok),
    .mem_data_ok(mem_data_ok)
);

// ==== tb_dcache.sv ====
`timescale 1ns/1ns

module tb_dcache;
    import dcache_pkg::*;

    localparam int INDEX_WIDTH = 4;
    localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int TIMEOUT     = 200;
    localparam int RANDOM_OPS  = 400;

    logic        clk;
    logic        rst;
    logic        cpu_req;
    logic        cpu_wr;
    logic [1:0]  cpu_size;
    logic [31:0] cpu_addr;
    logic [31:0] cpu_wdata;
    logic [31:0] cpu_rdata;
    logic        cpu_addr_ok;
    logic        cpu_data_ok;
    logic        mem_req;
    logic        mem_wr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;
    logic        mem_addr_ok;
    logic        mem_data_ok;

    // processor view of memory, keyed by word address
    logic [31:0] golden [logic [31:0]];

    int          access_cycles;
    logic        saw_mem_req;
    logic [31:0] first_mem_addr;
    logic [31:0] read_word;

    dcache_top #(.INDEX_WIDTH(INDEX_WIDTH)) i_dut (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_wr     (cpu_wr),
        .cpu_size   (cpu_size),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_rdata  (cpu_rdata),
        .cpu_addr_ok(cpu_addr_ok),
        .cpu_data_ok(cpu_data_ok),
        .mem_req    (mem_req),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok)
    );

    tb_mem i_mem (
        .clk        (clk),
        .rst        (rst),
        .mem_req    (mem_req),
        .mem_wr     (mem_wr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok)
    );

    always #4 clk = ~clk;

    //////////////////////////////
    // reference model
    //////////////////////////////

    // same pattern the memory model starts with
    function automatic logic [31:0] fill_word(input logic [31:0] key);
        return (key * 32'h9e37_79b1) ^ 32'h3c6e_f372;
    endfunction

    function automatic logic [31:0] golden_word(input logic [31:0] addr);
        logic [31:0] key;
        key = {addr[31:2], 2'b00};
        if (golden.exists(key)) begin
            return golden[key];
        end
        return fill_word(key);
    endfunction

    // bytes touched by a store of this size at this offset
    function automatic logic [3:0] lane_mask(input logic [1:0] size, input logic [1:0] offset);
        case (size)
            SIZE_BYTE: return 4'b0001 << offset;
            SIZE_HALF: return 4'b0011 << {offset[1], 1'b0};
            default:   return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] make_addr(input int tag_sel, input int set,
                                              input logic [1:0] offset);
        logic [TAG_WIDTH-1:0]   tag;
        logic [INDEX_WIDTH-1:0] index;
        tag   = TAG_WIDTH'(tag_sel * 32'h0005_3c17 + 7);
        index = INDEX_WIDTH'(set);
        return {tag, index, offset};
    endfunction

    //////////////////////////////
    // checks and accesses
    //////////////////////////////

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            stop_with_error($sformatf("[ERROR] %s: expected %h, actual %h",
                                      name, expected, actual));
        end
    endtask

    // entered 1 ns after a rising edge, leaves at the same point
    task automatic run_access(input string name, input logic wr, input logic [1:0] size,
                              input logic [31:0] addr, input logic [31:0] wdata);
        logic [3:0]  mask;
        logic [31:0] merged;
        logic        done;
        mask          = lane_mask(size, addr[1:0]);
        cpu_req       = 1'b1;
        cpu_wr        = wr;
        cpu_size      = size;
        cpu_addr      = addr;
        cpu_wdata     = wdata;
        access_cycles = 0;
        saw_mem_req   = 1'b0;
        done          = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (mem_req && !saw_mem_req) begin
                saw_mem_req    = 1'b1;
                first_mem_addr = mem_addr;
            end
            // dirty victim leaves the cache at the coming edge
            if (mem_req && mem_wr && mem_addr_ok) begin
                check_value({name, " write-back"}, golden_word(mem_addr), mem_wdata);
            end
            if (cpu_data_ok) begin
                check_value({name, " addr_ok"}, 32'd1, {31'd0, cpu_addr_ok});
                done      = 1'b1;
                read_word = cpu_rdata;
            end else if (access_cycles >= TIMEOUT) begin
                stop_with_error($sformatf("timeout: %s saw no cpu_data_ok within %0d cycles",
                                          name, TIMEOUT));
            end else begin
                check_value({name, " addr_ok"}, 32'd0, {31'd0, cpu_addr_ok});
                access_cycles++;
            end
            @(posedge clk);
        end
        #1;
        cpu_req = 1'b0;
        if (wr) begin
            merged = golden_word(addr);
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    merged[8*b +: 8] = wdata[8*b +: 8];
                end
            end
            golden[{addr[31:2], 2'b00}] = merged;
        end else begin
            check_value(name, golden_word(addr), read_word);
        end
    endtask

    task automatic read_hit(input string name, input logic [31:0] addr);
        run_access(name, 1'b0, SIZE_WORD, {addr[31:2], 2'b00}, 32'd0);
        check_value({name, " hit cycles"}, 32'd0, access_cycles);
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        logic [1:0]  size;
        logic [1:0]  offset;
        logic [31:0] addr;
        logic        wr;
        void'($urandom(32'h5965_5236));
        clk       = 1'b0;
        rst       = 1'b1;
        cpu_req   = 1'b0;
        cpu_wr    = 1'b0;
        cpu_size  = SIZE_WORD;
        cpu_addr  = 32'd0;
        cpu_wdata = 32'd0;

        repeat (10) begin
            @(posedge clk);
            #1;
            check_value("reset outputs", 32'd0, {29'd0, mem_req, cpu_addr_ok, cpu_data_ok});
        end
        rst = 1'b0;
        @(negedge clk);
        check_value("after reset outputs", 32'd0, {29'd0, mem_req, cpu_addr_ok, cpu_data_ok});
        @(posedge clk);
        #1;

        // five tags into set 3, the first one gets evicted
        for (int t = 0; t < 5; t++) begin
            run_access("fill set", 1'b0, SIZE_WORD, make_addr(t, 3, 2'b00), 32'd0);
        end
        for (int t = 1; t < 5; t++) begin
            read_hit("recent way", make_addr(t, 3, 2'b00));
        end
        run_access("evicted way", 1'b0, SIZE_WORD, make_addr(0, 3, 2'b00), 32'd0);
        check_value("evicted way mem_req", 32'd1, {31'd0, saw_mem_req});
        check_value("evicted way mem_addr", make_addr(0, 3, 2'b00), first_mem_addr);

        // six tags over two sets keep the ways under pressure
        for (int n = 0; n < RANDOM_OPS; n++) begin
            wr   = 1'($urandom_range(1, 0));
            size = 2'($urandom_range(2, 0));
            case (size)
                SIZE_BYTE: offset = 2'($urandom_range(3, 0));
                SIZE_HALF: offset = {1'($urandom_range(1, 0)), 1'b0};
                default:   offset = 2'b00;
            endcase
            addr = make_addr(int'($urandom_range(5, 0)), int'($urandom_range(1, 0)) * 5, offset);
            run_access("random access", wr, size, addr, $urandom);
            read_hit("repeat read", addr);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== all.f ====
dcache_pkg.sv
dcache_miss_if.sv
dcache_store.sv
dcache_replace.sv
dcache_miss_ctrl.sv
dcache_top.sv
tb_mem.sv
tb_dcache_assertions.sv
tb_dcache.sv

// ==== Makefile ====
TOP := tb_dcache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f all.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
